/* hdl/hiscore_params.svh */
`ifndef HISCORE_PARAMS_SVH
`define HISCORE_PARAMS_SVH

// ==================================================
// Widths
// ==================================================
`define HS_GAME_ADDR_W   16   // Game RAM address bits
`define HS_ENTRY_IDX_W   4    // Up to 16 entries
`define HS_SCORE_IDX_W   8    // Up to 256 dump bytes
`define HS_IOCTL_ADDR_W  25   // Host byte address bits

// Download indexes of the two images
`define HS_CONFIG_INDEX  3
`define HS_DUMP_INDEX    4

// ==================================================
// Config image layout
// ==================================================
`define HS_HEADER_BYTES  16   // Header ahead of the first entry
`define HS_ENTRY_BYTES   8    // One entry record

// Last byte of each big-endian header field
`define HS_HDR_START_WAIT_END  3
`define HS_HDR_CHECK_WAIT_END  5
`define HS_HDR_CHECK_HOLD_END  7
`define HS_HDR_WRITE_HOLD_END  9

// Byte positions inside an entry
`define HS_ENT_ADDR_END   3   // Last byte of the 4-byte address
`define HS_ENT_LEN        4
`define HS_ENT_START      5
`define HS_ENT_END        6

`endif

/* hdl/hs_pkg.sv */
`include "hiscore_params.svh"

package hs_pkg;

	// Vectors with a meaning of their own
	typedef logic [7:0]                    byte_t;      // Data byte on host and game RAM
	typedef logic [`HS_GAME_ADDR_W-1:0]    game_addr_t; // Address in game RAM
	typedef logic [`HS_ENTRY_IDX_W-1:0]    entry_idx_t; // Entry number in the table
	typedef logic [`HS_SCORE_IDX_W-1:0]    score_idx_t; // Byte position in the dump
	typedef logic [31:0]                   delay_t;     // Start delay and wait counter
	typedef logic [15:0]                   hold_t;      // Check wait and hold times

	// ==================================================
	// Restore FSM
	// ==================================================
	typedef enum logic [3:0]
	{
		ST_IDLE,        // Waiting for both images
		ST_START_DELAY, // Counting down start_wait
		ST_ENTRY_SETUP, // Entry table settles on new index
		ST_START_CHECK, // Reading first address of entry
		ST_END_CHECK,   // Reading last address of entry
		ST_RETRY_WAIT,  // Back off after a failed check
		ST_WRITE_SETUP, // Table and dump buffer settle
		ST_WRITE_HOLD,  // ram_write held high
		ST_NEXT_BYTE,   // Step to next address or entry
		ST_DONE         // Restore finished until next reset
	} restore_state_t;

endpackage

/* hdl/hs_config_loader.sv */
`include "hiscore_params.svh"

module hs_config_loader
	import hs_pkg::*;
(
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        ioctl_download,
	input  logic                        ioctl_wr,
	input  logic [`HS_IOCTL_ADDR_W-1:0] ioctl_addr,
	input  byte_t                       ioctl_dout,
	input  byte_t                       ioctl_index,
	output logic                        entry_we,
	output entry_idx_t                  entry_widx,
	output game_addr_t                  entry_addr,
	output byte_t                       entry_len,
	output byte_t                       entry_start,
	output byte_t                       entry_end,
	output logic                        score_we,
	output entry_idx_t                  last_entry,
	output logic                        config_loaded,
	output logic                        dump_loaded,
	output delay_t                      start_wait,
	output hold_t                       check_wait,
	output hold_t                       check_hold,
	output hold_t                       write_hold
);

	localparam int POS_W = $clog2(`HS_ENTRY_BYTES);  // Bits of byte position in an entry
	localparam int HDR_W = $clog2(`HS_HEADER_BYTES); // Bits of byte position in the header

	logic                        byte_take;  // Host byte strobe
	logic                        cfg_take;   // Byte belongs to config image
	logic                        in_header;
	logic [`HS_IOCTL_ADDR_W-1:0] entry_off;  // Byte offset past the header
	logic [POS_W-1:0]            entry_pos;
	byte_t                       hist0;      // Most recent byte
	byte_t                       hist1;
	byte_t                       hist2;      // Oldest of the three
	logic [31:0]                 word32;     // Big-endian word ending at current byte
	logic                        dl_last;    // ioctl_download one cycle back
	byte_t                       idx_last;   // ioctl_index one cycle back

	assign byte_take = ioctl_download & ioctl_wr;
	assign cfg_take  = byte_take & (ioctl_index == `HS_CONFIG_INDEX);
	assign score_we  = byte_take & (ioctl_index == `HS_DUMP_INDEX); // Buffer takes addr/data itself
	assign in_header = (ioctl_addr < `HS_HEADER_BYTES);
	assign entry_off = ioctl_addr - `HS_HEADER_BYTES;
	assign entry_pos = entry_off[POS_W-1:0];
	assign word32    = {hist2, hist1, hist0, ioctl_dout};

	// Whole record goes to the table on the end-value byte
	assign entry_we   = cfg_take & ~in_header & (entry_pos == `HS_ENT_END);
	assign entry_widx = entry_off[POS_W +: `HS_ENTRY_IDX_W];
	assign entry_end  = ioctl_dout;

	// ==================================================
	// Byte history and field capture
	// ==================================================
	always_ff @(posedge clk)
	begin
		if (byte_take)
		begin
			hist2 <= hist1;
			hist1 <= hist0;
			hist0 <= ioctl_dout;
		end
	end

	// Header fields complete on their last byte
	always_ff @(posedge clk)
	begin
		if (cfg_take && in_header)
		begin
			case (ioctl_addr[HDR_W-1:0])
				`HS_HDR_START_WAIT_END: start_wait <= word32;
				`HS_HDR_CHECK_WAIT_END: check_wait <= word32[15:0];
				`HS_HDR_CHECK_HOLD_END: check_hold <= word32[15:0];
				`HS_HDR_WRITE_HOLD_END: write_hold <= word32[15:0];
				default: ;                                       // Repeat fields and pad
			endcase
		end
	end

	// Address, length and start value wait here for the end byte
	always_ff @(posedge clk)
	begin
		if (cfg_take && !in_header)
		begin
			case (entry_pos)
				`HS_ENT_ADDR_END: entry_addr  <= word32[`HS_GAME_ADDR_W-1:0]; // Low bits only
				`HS_ENT_LEN:      entry_len   <= ioctl_dout;
				`HS_ENT_START:    entry_start <= ioctl_dout;
				default: ;
			endcase
		end
	end

	// ==================================================
	// Image completion
	// ==================================================
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			dl_last       <= 1'b0;
			idx_last      <= '0;
			last_entry    <= '0;
			config_loaded <= 1'b0;
			dump_loaded   <= 1'b0;
		end
		else
		begin
			dl_last  <= ioctl_download;
			idx_last <= ioctl_index;
			if (entry_we)
				last_entry <= entry_widx; // Entries arrive in ascending order
			// Falling edge of download closes the image seen just before
			if (dl_last && !ioctl_download)
			begin
				if (idx_last == `HS_CONFIG_INDEX)
					config_loaded <= 1'b1;
				if (idx_last == `HS_DUMP_INDEX)
					dump_loaded <= 1'b1;
			end
		end
	end

endmodule

/* hdl/hs_entry_table.sv */
`include "hiscore_params.svh"

module hs_entry_table
	import hs_pkg::*;
(
	input  logic       clk,
	input  logic       we,
	input  entry_idx_t widx,
	input  game_addr_t waddr,
	input  byte_t      wlen,
	input  byte_t      wstart,
	input  byte_t      wend,
	input  entry_idx_t ridx,
	output game_addr_t base_addr,
	output game_addr_t end_addr,
	output byte_t      length,
	output byte_t      start_val,
	output byte_t      end_val
);

	localparam int DEPTH = 2 ** `HS_ENTRY_IDX_W;

	game_addr_t addr_mem  [DEPTH]; // First game RAM address of each entry
	byte_t      len_mem   [DEPTH];
	byte_t      start_mem [DEPTH]; // Value expected at first address
	byte_t      end_mem   [DEPTH]; // Value expected at last address

	// Write port from the loader
	always_ff @(posedge clk)
	begin
		if (we)
		begin
			addr_mem[widx]  <= waddr;
			len_mem[widx]   <= wlen;
			start_mem[widx] <= wstart;
			end_mem[widx]   <= wend;
		end
	end

	// Registered read with the last address precomputed for the engine
	always_ff @(posedge clk)
	begin
		base_addr <= addr_mem[ridx];
		length    <= len_mem[ridx];
		start_val <= start_mem[ridx];
		end_val   <= end_mem[ridx];
		end_addr  <= addr_mem[ridx] + game_addr_t'(len_mem[ridx]) - 1'b1; // base + len - 1
	end

endmodule

/* hdl/hs_score_buffer.sv */
`include "hiscore_params.svh"

module hs_score_buffer
	import hs_pkg::*;
(
	input  logic       clk,
	input  logic       we,
	input  score_idx_t waddr,
	input  byte_t      wdata,
	input  score_idx_t raddr,
	output byte_t      rdata
);

	localparam int DEPTH = 2 ** `HS_SCORE_IDX_W; // One byte per dump position

	byte_t mem [DEPTH];

	// ==================================================
	// Dump image store
	// ==================================================
	always_ff @(posedge clk)
	begin
		if (we)
			mem[waddr] <= wdata; // Host download side
	end

	// Read side feeds data_to_ram straight through
	always_ff @(posedge clk)
	begin
		rdata <= mem[raddr];
	end

endmodule

/* hdl/hs_restore_engine.sv */
`include "hiscore_params.svh"

module hs_restore_engine
	import hs_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       config_loaded,
	input  logic       dump_loaded,
	input  delay_t     start_wait,
	input  hold_t      check_wait,
	input  hold_t      check_hold,
	input  hold_t      write_hold,
	input  entry_idx_t last_entry,
	input  game_addr_t base_addr,
	input  game_addr_t end_addr,
	input  byte_t      start_val,
	input  byte_t      end_val,
	input  byte_t      ram_rdata,
	output entry_idx_t entry_idx,
	output score_idx_t score_idx,
	output game_addr_t ram_address,
	output logic       ram_write,
	output logic       ram_access
);

	restore_state_t state;
	delay_t         timer;       // Shared by delay, hold and retry waits
	game_addr_t     offset;      // Write position inside current entry
	game_addr_t     write_addr;
	logic           check_live;  // Past the first cycle of a check read

	assign write_addr = base_addr + offset;
	assign check_live = (timer != delay_t'(check_hold)); // First cycle still has the old read

	// ==================================================
	// Game RAM side
	// ==================================================
	always_comb
	begin
		case (state)
			ST_START_CHECK: ram_address = base_addr;
			ST_END_CHECK:   ram_address = end_addr;
			default:        ram_address = write_addr;
		endcase
	end

	assign ram_write  = (state == ST_WRITE_HOLD);
	// Retry wait drops access so the game runs freely between attempts
	assign ram_access = state inside {ST_ENTRY_SETUP, ST_START_CHECK, ST_END_CHECK,
		ST_WRITE_SETUP, ST_WRITE_HOLD, ST_NEXT_BYTE};

	// ==================================================
	// Restore FSM
	// ==================================================
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state     <= ST_IDLE;
			timer     <= '0;
			entry_idx <= '0;
			score_idx <= '0;
			offset    <= '0;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					if (config_loaded && dump_loaded)
					begin
						entry_idx <= '0;
						if (start_wait == '0)
							state <= ST_ENTRY_SETUP;      // No delay requested
						else
						begin
							timer <= start_wait - 1'b1;  // Idle cycle counts as one
							state <= ST_START_DELAY;
						end
					end
				end

				ST_START_DELAY:
				begin
					if (timer == '0)
						state <= ST_ENTRY_SETUP;
					else
						timer <= timer - 1'b1;
				end

				ST_ENTRY_SETUP:
				begin
					timer <= delay_t'(check_hold); // Table output valid from next cycle
					state <= ST_START_CHECK;
				end

				ST_START_CHECK:
				begin
					if (check_live && (ram_rdata == start_val))
					begin
						timer <= delay_t'(check_hold);
						state <= ST_END_CHECK;
					end
					else if (timer == '0)
					begin
						timer <= delay_t'(check_wait); // Give up and back off
						state <= ST_RETRY_WAIT;
					end
					else
						timer <= timer - 1'b1;
				end

				ST_END_CHECK:
				begin
					if (check_live && (ram_rdata == end_val))
					begin
						if (entry_idx == last_entry)
						begin
							// All entries match so start copying
							entry_idx <= '0;
							score_idx <= '0;
							offset    <= '0;
							state     <= ST_WRITE_SETUP;
						end
						else
						begin
							entry_idx <= entry_idx + 1'b1;
							state     <= ST_ENTRY_SETUP;
						end
					end
					else if (timer == '0)
					begin
						timer <= delay_t'(check_wait);
						state <= ST_RETRY_WAIT;
					end
					else
						timer <= timer - 1'b1;
				end

				ST_RETRY_WAIT:
				begin
					if (timer < 2)
					begin
						entry_idx <= '0; // Checks restart from the first entry
						state     <= ST_ENTRY_SETUP;
					end
					else
						timer <= timer - 1'b1;
				end

				ST_WRITE_SETUP:
				begin
					timer <= delay_t'(write_hold); // Dump byte and base valid next cycle
					state <= ST_WRITE_HOLD;
				end

				ST_WRITE_HOLD:
				begin
					if (timer == '0)
						state <= ST_NEXT_BYTE;
					else
						timer <= timer - 1'b1;
				end

				ST_NEXT_BYTE:
				begin
					score_idx <= score_idx + 1'b1; // Dump is one flat run over all entries
					if (write_addr == end_addr)
					begin
						if (entry_idx == last_entry)
							state <= ST_DONE;
						else
						begin
							entry_idx <= entry_idx + 1'b1;
							offset    <= '0;
							state     <= ST_WRITE_SETUP;
						end
					end
					else
					begin
						offset <= offset + 1'b1;
						state  <= ST_WRITE_SETUP;
					end
				end

				ST_DONE:
					state <= ST_DONE; // Held until rst_n

				default:
					state <= ST_IDLE;
			endcase
		end
	end

endmodule

/* hdl/hiscore_top.sv */
`include "hiscore_params.svh"

module hiscore_top
	import hs_pkg::*;
(
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        ioctl_download,
	input  logic                        ioctl_wr,
	input  logic [`HS_IOCTL_ADDR_W-1:0] ioctl_addr,
	input  byte_t                       ioctl_dout,
	input  byte_t                       ioctl_index,
	input  byte_t                       ram_rdata,
	output game_addr_t                  ram_address,
	output byte_t                       data_to_ram,
	output logic                        ram_write,
	output logic                        ram_access
);

	// ==================================================
	// Loader outputs
	// ==================================================
	logic       entry_we;
	entry_idx_t entry_widx;
	game_addr_t entry_waddr;
	byte_t      entry_wlen;
	byte_t      entry_wstart;
	byte_t      entry_wend;
	logic       score_we;
	entry_idx_t last_entry;
	logic       config_loaded;
	logic       dump_loaded;
	delay_t     start_wait;
	hold_t      check_wait;
	hold_t      check_hold;
	hold_t      write_hold;

	// Engine side of the two memories
	entry_idx_t entry_idx;
	score_idx_t score_idx;
	game_addr_t base_addr;
	game_addr_t end_addr;
	byte_t      start_val;
	byte_t      end_val;

	hs_config_loader i_loader
	(
		.clk            (clk),
		.rst_n          (rst_n),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_index    (ioctl_index),
		.entry_we       (entry_we),
		.entry_widx     (entry_widx),
		.entry_addr     (entry_waddr),
		.entry_len      (entry_wlen),
		.entry_start    (entry_wstart),
		.entry_end      (entry_wend),
		.score_we       (score_we),
		.last_entry     (last_entry),
		.config_loaded  (config_loaded),
		.dump_loaded    (dump_loaded),
		.start_wait     (start_wait),
		.check_wait     (check_wait),
		.check_hold     (check_hold),
		.write_hold     (write_hold)
	);

	// Length stays inside the table as the engine only needs end_addr
	hs_entry_table i_entry_table
	(
		.clk       (clk),
		.we        (entry_we),
		.widx      (entry_widx),
		.waddr     (entry_waddr),
		.wlen      (entry_wlen),
		.wstart    (entry_wstart),
		.wend      (entry_wend),
		.ridx      (entry_idx),
		.base_addr (base_addr),
		.end_addr  (end_addr),
		.length    (),
		.start_val (start_val),
		.end_val   (end_val)
	);

	hs_score_buffer i_score_buffer
	(
		.clk   (clk),
		.we    (score_we),
		.waddr (ioctl_addr[`HS_SCORE_IDX_W-1:0]), // Dump byte position from host
		.wdata (ioctl_dout),
		.raddr (score_idx),
		.rdata (data_to_ram)
	);

	hs_restore_engine i_restore_engine
	(
		.clk           (clk),
		.rst_n         (rst_n),
		.config_loaded (config_loaded),
		.dump_loaded   (dump_loaded),
		.start_wait    (start_wait),
		.check_wait    (check_wait),
		.check_hold    (check_hold),
		.write_hold    (write_hold),
		.last_entry    (last_entry),
		.base_addr     (base_addr),
		.end_addr      (end_addr),
		.start_val     (start_val),
		.end_val       (end_val),
		.ram_rdata     (ram_rdata),
		.entry_idx     (entry_idx),
		.score_idx     (score_idx),
		.ram_address   (ram_address),
		.ram_write     (ram_write),
		.ram_access    (ram_access)
	);

endmodule

/* testbench/tb_clock_gen.sv */
module tb_clock_gen
(
	output logic clk,
	output logic rst_n
);

	timeunit 1ns;
	timeprecision 1ps;

	// 40 ns period
	initial
	begin
		clk = 1'b0;
		forever
			#20 clk = ~clk;
	end

	// Power-on reset held low for three rising edges
	initial
	begin
		rst_n = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

/* testbench/tb_hiscore.sv */
module tb_hiscore;

	timeunit 1ns;
	timeprecision 1ps;

	logic        clk, gen_rst_n, rst_n, test_rst_n;
	logic        ioctl_download, ioctl_wr;
	logic [24:0] ioctl_addr;
	logic [7:0]  ioctl_dout, ioctl_index, ram_rdata, data_to_ram;
	logic [15:0] ram_address;
	logic        ram_write, ram_access;

	logic [7:0]  mem [0:65535];     // Game RAM model
	logic [7:0]  cfg [0:271];       // Config image as sent
	logic [7:0]  dump_b [0:255];
	int          ent_addr [16], ent_len [16], ent_start [16], ent_end [16];
	int          n_ent, n_dump, sw, cw, ch, wh, config_only;
	int          pre_addr [$], pre_val [$], exp_addr [$], exp_val [$];
	int          late_addr, late_val, late_cyc;
	bit          has_late;
	string       cur_name;
	int          errors, n_tests, n_failed;
	int          pulses, run_len;   // Write pulse monitor
	logic [15:0] run_addr;
	logic        wr_prev, wr_q;
	logic [15:0] addr_q;
	logic [7:0]  data_q;

	assign rst_n = gen_rst_n & test_rst_n;

	tb_clock_gen i_clock_gen (.clk(clk), .rst_n(gen_rst_n));

	hiscore_top i_hiscore_top
	(
		.clk(clk), .rst_n(rst_n), .ioctl_download(ioctl_download), .ioctl_wr(ioctl_wr),
		.ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout), .ioctl_index(ioctl_index),
		.ram_rdata(ram_rdata), .ram_address(ram_address), .data_to_ram(data_to_ram),
		.ram_write(ram_write), .ram_access(ram_access)
	);

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act)
		begin
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	// True when the address lies inside some entry range
	function automatic bit in_range(input int a);
		bit hit;
		hit = 0;
		for (int i = 0; i < n_ent; i++)
			if (a >= ent_addr[i] && a <= ent_addr[i] + ent_len[i] - 1)
				hit = 1;
		return hit;
	endfunction

	// ==================================================
	// Game RAM model and write monitor
	// ==================================================
	always @(negedge clk)
	begin
		ram_rdata = mem[ram_address];
		wr_q      = ram_write;        // Latched here and stored on the rising edge
		addr_q    = ram_address;
		data_q    = data_to_ram;
		if (ram_write)
		begin
			if (!wr_prev)
			begin
				run_len  = 1;
				run_addr = ram_address;
			end
			else
				run_len++;
			check_value({cur_name, " write address"}, run_addr, ram_address); // Held address
		end
		else if (wr_prev)
		begin
			pulses++;
			check_value({cur_name, " write hold"}, wh + 1, run_len);
			check_value({cur_name, " write in range"}, 1, in_range(run_addr));
		end
		wr_prev = ram_write;
	end

	always @(posedge clk)
		if (wr_q)
			mem[addr_q] = data_q;

	task automatic send_image(input int index, input int n, input bit is_cfg);
		@(negedge clk);
		ioctl_index    = 8'(index);
		ioctl_download = 1'b1;
		for (int i = 0; i < n; i++)
		begin
			@(negedge clk);
			ioctl_wr   = 1'b1;
			ioctl_addr = 25'(i);
			ioctl_dout = is_cfg ? cfg[i] : dump_b[i];
		end
		@(negedge clk);
		ioctl_wr = 1'b0;
		@(negedge clk);
		ioctl_download = 1'b0; // Index kept through the fall
		@(negedge clk);
	endtask

	// Header and entries laid out big-endian
	task automatic build_config();
		for (int i = 0; i < 272; i++)
			cfg[i] = 8'h00;
		{cfg[0], cfg[1], cfg[2], cfg[3]} = 32'(sw);
		{cfg[4], cfg[5]} = 16'(cw);
		{cfg[6], cfg[7]} = 16'(ch);
		{cfg[8], cfg[9]} = 16'(wh);
		for (int e = 0; e < n_ent; e++)
		begin
			{cfg[16+8*e], cfg[17+8*e], cfg[18+8*e], cfg[19+8*e]} = 32'(ent_addr[e]);
			cfg[20+8*e] = 8'(ent_len[e]);
			cfg[21+8*e] = 8'(ent_start[e]);
			cfg[22+8*e] = 8'(ent_end[e]);
		end
	endtask

	task automatic run_test();
		int err0, total, cyc, first_acc, late_pulses;
		bit finished;
		err0 = errors;
		total = 0;
		first_acc = -1;
		late_pulses = -1;              // Stays negative if the late change never happened
		finished = 0;
		for (int i = 0; i < n_ent; i++)
			total += ent_len[i];
		for (int a = 0; a < 65536; a++)
			mem[a] = 8'h00;
		foreach (pre_addr[i])
			mem[pre_addr[i]] = 8'(pre_val[i]);
		build_config();
		@(negedge clk);
		test_rst_n = 1'b0;
		repeat (3) @(negedge clk);
		test_rst_n = 1'b1;
		pulses = 0;
		send_image(3, 16 + 8 * n_ent, 1);
		if (config_only)
		begin
			// Nothing may touch game RAM without the dump
			for (int c = 0; c < 500; c++)
			begin
				@(negedge clk);
				check_value({cur_name, " idle access"}, 0, {ram_access, ram_write});
			end
		end
		else
		begin
			send_image(4, n_dump, 0);
			for (cyc = 1; cyc <= 20000 && !finished; cyc++)
			begin
				@(negedge clk);
				if (has_late && cyc == late_cyc)
				begin
					late_pulses = pulses;
					mem[late_addr] = 8'(late_val);
				end
				if (ram_access && first_acc < 0)
					first_acc = cyc;
				if (pulses == total && !ram_access)
					finished = 1;
			end
			if (!finished)
			begin
				$display("timeout waiting for restore end in %s", cur_name);
				errors++;
			end
			check_value({cur_name, " start delay"}, 1, first_acc >= sw);
			if (has_late)
				check_value({cur_name, " writes before fix"}, 0, late_pulses);
			for (int c = 0; c < 200; c++)
			begin
				@(negedge clk);
				check_value({cur_name, " access after done"}, 0, {ram_access, ram_write});
			end
			check_value({cur_name, " write count"}, total, pulses);
			foreach (exp_addr[i])
				check_value({cur_name, " ram byte"}, exp_val[i], mem[exp_addr[i]]);
		end
		n_tests++;
		if (errors != err0)
			n_failed++;
		$display("test %s: %s", cur_name, (errors == err0) ? "ok" : "errors");
	endtask

	// ==================================================
	// Test file reader
	// ==================================================
	initial
	begin
		int fd, n;
		int v [9];
		string line, kw;
		ioctl_download = 0;
		ioctl_wr = 0;
		ioctl_addr = 0;
		ioctl_dout = 0;
		ioctl_index = 0;
		ram_rdata = 0;
		test_rst_n = 1;
		wr_prev = 0;
		wr_q = 0;
		errors = 0;
		n_tests = 0;
		n_failed = 0;
		fd = $fopen("testbench/hiscore_tests.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the test file");
			errors++;
		end
		else
		begin
			for (int c = 0; c < 20 && gen_rst_n !== 1'b1; c++)
				@(negedge clk);
			if (gen_rst_n !== 1'b1)
			begin
				$display("timeout waiting for reset release");
				errors++;
				fd = 0;
			end
		end
		while (fd != 0 && $fgets(line, fd) != 0)
		begin
			kw = "";
			n = $sscanf(line, "%s %h %h %h %h %h %h %h %h", kw,
				v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
			if (kw == "test")
			begin
				n = $sscanf(line, "%s %s %d", kw, cur_name, config_only);
				n_ent = 0;
				n_dump = 0;
				has_late = 0;
				pre_addr.delete();
				pre_val.delete();
				exp_addr.delete();
				exp_val.delete();
			end
			else if (kw == "hdr")
			begin
				sw = v[0];
				cw = v[1];
				ch = v[2];
				wh = v[3];
			end
			else if (kw == "entry")
			begin
				ent_addr[n_ent]  = v[0];
				ent_len[n_ent]   = v[1];
				ent_start[n_ent] = v[2];
				ent_end[n_ent]   = v[3];
				n_ent++;
			end
			else if (kw == "dump")
				for (int k = 0; k < n - 1; k++)
				begin
					dump_b[n_dump] = 8'(v[k]);
					n_dump++;
				end
			else if (kw == "preset")
			begin
				pre_addr.push_back(v[0]);
				pre_val.push_back(v[1]);
			end
			else if (kw == "late")
			begin
				has_late  = 1;
				late_addr = v[0];
				late_val  = v[1];
				late_cyc  = v[2];
			end
			else if (kw == "expect")
				for (int k = 1; k < n - 1; k++)
				begin
					exp_addr.push_back(v[0] + k - 1);
					exp_val.push_back(v[k]);
				end
			else if (kw == "end")
				run_test();
		end
		$display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, errors);
		if (errors == 0 && n_tests > 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

/* testbench/hiscore_tests.txt */
# Lines: test name config_only | hdr start_wait check_wait check_hold write_hold (hex)
# entry addr len start end | dump bytes | preset addr val | late addr val cycles | expect addr bytes
test match 0
hdr 14 1e 2 1
entry 1000 3 11 33
entry 2004 2 a5 5a
dump 01 02 03 04 05
preset 1000 11
preset 1002 33
preset 2004 a5
preset 2005 5a
expect 1000 01 02 03
expect 2004 04 05
end
test start_retry 0
hdr 14 1e 2 1
entry 1000 3 11 33
entry 2004 2 a5 5a
dump 01 02 03 04 05
preset 1000 00
preset 1002 33
preset 2004 a5
preset 2005 5a
late 1000 11 100
expect 1000 01 02 03
expect 2004 04 05
end
test end_retry 0
hdr 14 1e 2 1
entry 1000 3 11 33
entry 2004 2 a5 5a
dump 01 02 03 04 05
preset 1000 11
preset 1002 33
preset 2004 a5
preset 2005 00
late 2005 5a 100
expect 1000 01 02 03
expect 2004 04 05
end
test long_hold 0
hdr 80 10 3 3
entry 0040 1 77 77
entry 3000 4 c0 c3
dump 9a 10 20 30 40
preset 0040 77
preset 3000 c0
preset 3003 c3
expect 0040 9a
expect 3000 10 20 30 40
end
test config_only 1
hdr 14 1e 2 1
entry 1000 3 11 33
end

/* hiscore.f */
+incdir+hdl
hdl/hs_pkg.sv
hdl/hs_config_loader.sv
hdl/hs_entry_table.sv
hdl/hs_score_buffer.sv
hdl/hs_restore_engine.sv
hdl/hiscore_top.sv
testbench/tb_clock_gen.sv
testbench/tb_hiscore.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
rm -f sim.log
verilator --binary --timing -f hiscore.f --top-module tb_hiscore -o tb_hiscore \
	&& ./obj_dir/tb_hiscore > sim.log 2>&1 \
	|| echo "build or run error" >> sim.log
cat sim.log
grep -q "^Simulation PASSED$" sim.log && exit 0 || exit 1
